/* uart_top.f */
+incdir+.
verilog/uart_pkg.sv
verilog/uart_fifo_if.sv
verilog/uart_baud_gen.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
tb/uart_tb.sv

/* Makefile */
# Verilator build and run of the UART testbench

SIM := obj_dir/Vuart_tb

.PHONY: all run clean

all: run

$(SIM): uart_top.f uart_settings.svh $(wildcard verilog/*.sv) tb/uart_tb.sv
	verilator --binary --timing --assert --top-module uart_tb -f uart_top.f -o Vuart_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

/* tb/uart_tb.sv */
// UART testbench
// Random bytes through the register bus and the serial line,
// checked against queue models of both FIFOs and the sticky flags

`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_tb;

	import uart_pkg::*;

	localparam int CLK_NS     = 4;
	localparam int BIT_CYCLES = 16 * `UART_BAUD_DIV;
	localparam int FIFO_DEPTH = 1 << `UART_FIFO_DEPTH_LOG2;
	// Transmit, receive, overrun, framing and interrupt frames
	localparam int N_FRAMES   = 20 + 12 + (FIFO_DEPTH + 1) + 2 + 3;
	localparam int TIMEOUT_NS = N_FRAMES * 10 * BIT_CYCLES * CLK_NS * 2 + 20000;

	logic        uart_clk;
	logic        reset;
	logic        uart_rx_i;
	logic        uart_tx_o;
	logic        irq_rx_o;
	logic        irq_tx_o;
	logic [1:0]  bus_adr;
	logic [31:0] bus_dat_i;
	logic        bus_we;
	logic        bus_stb;
	logic [31:0] bus_dat_o;
	logic        bus_ack_o;

	integer      seed;
	int          pass_count;
	int          fail_count;
	logic [7:0]  exp_tx_q[$];
	logic [7:0]  exp_rx_q[$];
	logic [7:0]  mon_q[$];
	logic        model_overrun;
	logic        model_frame_err;

	uart_top uut (
		.uart_clk  (uart_clk),
		.reset     (reset),
		.uart_rx_i (uart_rx_i),
		.uart_tx_o (uart_tx_o),
		.irq_rx_o  (irq_rx_o),
		.irq_tx_o  (irq_tx_o),
		.bus_adr_i (bus_adr),
		.bus_dat_i (bus_dat_i),
		.bus_we_i  (bus_we),
		.bus_stb_i (bus_stb),
		.bus_dat_o (bus_dat_o),
		.bus_ack_o (bus_ack_o)
	);

	initial begin
		uart_clk = 1'b0;
		forever #(CLK_NS / 2) uart_clk = ~uart_clk;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Run stopped: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("TEST FAILED");
		$finish;
	end

	// --------------------------------------------------
	// Result checks
	// --------------------------------------------------
	task automatic report_error(input string msg);
		fail_count++;
		$display("ERROR: %s", msg);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp_val,
			input logic [7:0] act_val);
		if (exp_val === act_val) begin
			pass_count++;
			$display("ok     %s: %h", name, act_val);
		end else begin
			fail_count++;
			$display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
		end
	endtask

	task automatic check_status(input string name, input logic [4:0] exp_val,
			input logic [4:0] act_val);
		if (exp_val === act_val) begin
			pass_count++;
			$display("ok     %s: %b", name, act_val);
		end else begin
			fail_count++;
			$display("FAILED %s: expected %b, actual %b", name, exp_val, act_val);
		end
	endtask

	task automatic check_irq(input string name, input logic [1:0] exp_val,
			input logic [1:0] act_val);
		if (exp_val === act_val) begin
			pass_count++;
			$display("ok     %s: %b", name, act_val);
		end else begin
			fail_count++;
			$display("FAILED %s: expected %b, actual %b", name, exp_val, act_val);
		end
	endtask

	// Status as the model sees it
	function automatic logic [4:0] expected_status(input logic tx_full, input logic tx_idle);
		logic [4:0] st;
		st               = '0;
		st[ST_RX_AVAIL]  = (exp_rx_q.size() != 0);
		st[ST_TX_FULL]   = tx_full;
		st[ST_TX_IDLE]   = tx_idle;
		st[ST_OVERRUN]   = model_overrun;
		st[ST_FRAME_ERR] = model_frame_err;
		return st;
	endfunction

	// --------------------------------------------------
	// Bus master
	// --------------------------------------------------
	task automatic bus_access(input logic [1:0] adr, input logic we,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int wait_cnt;
		@(negedge uart_clk);
		bus_adr   = adr;
		bus_we    = we;
		bus_dat_i = wdata;
		bus_stb   = 1'b1;
		wait_cnt  = 0;
		do begin
			@(negedge uart_clk);
			wait_cnt++;
		end while (!bus_ack_o && wait_cnt < 8);
		if (!bus_ack_o)
			report_error("bus access got no acknowledge");
		rdata   = bus_dat_o;
		bus_stb = 1'b0;
		bus_we  = 1'b0;
	endtask

	task automatic bus_write(input logic [1:0] adr, input logic [31:0] wdata);
		logic [31:0] unused;
		bus_access(adr, 1'b1, wdata, unused);
	endtask

	task automatic bus_read(input logic [1:0] adr, output logic [31:0] rdata);
		bus_access(adr, 1'b0, 32'h0, rdata);
	endtask

	// Wait for TX_FULL to clear, then push one byte
	task automatic write_tx_byte(input logic [7:0] d);
		logic [31:0] st;
		st = '1;
		while (st[ST_TX_FULL])
			bus_read(REG_STATUS, st);
		bus_write(REG_DATA, {24'h0, d});
		exp_tx_q.push_back(d);
	endtask

	task automatic wait_tx_done(input string name, input int n);
		logic [31:0] st;
		int          k;
		while (mon_q.size() < n)
			@(negedge uart_clk);
		st = '0;
		while (!st[ST_TX_IDLE])
			bus_read(REG_STATUS, st);
		for (k = 0; k < n; k++)
			check_byte($sformatf("%s %0d", name, k), exp_tx_q.pop_front(), mon_q.pop_front());
		if (mon_q.size() != 0)
			report_error("monitor decoded more TX bytes than were written");
	endtask

	// Status then data, an empty FIFO reads as zero
	task automatic read_and_check_rx(input string name);
		logic [31:0] rdata;
		logic [7:0]  exp_val;
		bus_read(REG_STATUS, rdata);
		check_status({name, " status"}, expected_status(1'b0, 1'b1), rdata[4:0]);
		bus_read(REG_DATA, rdata);
		exp_val = (exp_rx_q.size() != 0) ? exp_rx_q.pop_front() : 8'h00;
		check_byte({name, " data"}, exp_val, rdata[7:0]);
	endtask

	// --------------------------------------------------
	// Serial driver and monitor
	// --------------------------------------------------
	task automatic send_frame(input logic [7:0] d, input logic bad_stop);
		int i;
		@(negedge uart_clk);
		uart_rx_i = 1'b0;
		repeat (BIT_CYCLES) @(negedge uart_clk);
		for (i = 0; i < 8; i++) begin
			uart_rx_i = d[i];
			repeat (BIT_CYCLES) @(negedge uart_clk);
		end
		uart_rx_i = !bad_stop;
		repeat (BIT_CYCLES) @(negedge uart_clk);
		// One idle bit between frames
		uart_rx_i = 1'b1;
		repeat (BIT_CYCLES) @(negedge uart_clk);
		if (bad_stop)
			model_frame_err = 1'b1;
		else if (exp_rx_q.size() == FIFO_DEPTH)
			model_overrun = 1'b1;
		else
			exp_rx_q.push_back(d);
	endtask

	initial begin : tx_monitor
		logic [7:0] d;
		int         i;
		forever begin
			@(negedge uart_tx_o);
			repeat (BIT_CYCLES / 2) @(negedge uart_clk);
			if (uart_tx_o !== 1'b0)
				report_error("TX start bit was not low at its middle");
			for (i = 0; i < 8; i++) begin
				repeat (BIT_CYCLES) @(negedge uart_clk);
				d[i] = uart_tx_o;
			end
			repeat (BIT_CYCLES) @(negedge uart_clk);
			if (uart_tx_o !== 1'b1)
				report_error("TX stop bit was low");
			mon_q.push_back(d);
		end
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin : main
		logic [31:0] rdata;
		int          i;
		reset           = 1'b1;
		uart_rx_i       = 1'b1;
		bus_adr         = 2'b00;
		bus_dat_i       = 32'h0;
		bus_we          = 1'b0;
		bus_stb         = 1'b0;
		seed            = 32'h2690947c;
		pass_count      = 0;
		fail_count      = 0;
		model_overrun   = 1'b0;
		model_frame_err = 1'b0;
		repeat (4) @(negedge uart_clk);
		reset = 1'b0;

		// Reset state
		bus_read(REG_STATUS, rdata);
		check_status("reset status", expected_status(1'b0, 1'b1), rdata[4:0]);
		bus_read(REG_IRQ_EN, rdata);
		check_byte("reset irq enable", 8'h00, rdata[7:0]);
		check_irq("reset irq", 2'b00, {irq_tx_o, irq_rx_o});
		check_byte("reset tx line", 8'h01, {7'b0, uart_tx_o});

		// Transmit, a long burst runs into TX_FULL
		for (i = 0; i < 20; i++) begin
			if (i == 18)
				repeat (3 * BIT_CYCLES) @(negedge uart_clk);
			write_tx_byte(8'($random(seed)));
		end
		wait_tx_done("tx byte", 20);

		// Receive
		for (i = 0; i < 12; i++)
			send_frame(8'($random(seed)), 1'b0);
		for (i = 0; i < 12; i++)
			read_and_check_rx($sformatf("rx byte %0d", i));
		read_and_check_rx("rx empty");

		// Overrun, one frame more than the FIFO holds
		for (i = 0; i < FIFO_DEPTH + 1; i++)
			send_frame(8'($random(seed)), 1'b0);
		bus_read(REG_STATUS, rdata);
		check_status("overrun set", expected_status(1'b0, 1'b1), rdata[4:0]);
		bus_write(REG_STATUS, 32'h1 << ST_OVERRUN);
		model_overrun = 1'b0;
		bus_read(REG_STATUS, rdata);
		check_status("overrun cleared", expected_status(1'b0, 1'b1), rdata[4:0]);
		for (i = 0; i < FIFO_DEPTH; i++)
			read_and_check_rx($sformatf("overrun byte %0d", i));
		read_and_check_rx("overrun lost byte");

		// Framing error, then a good frame
		send_frame(8'($random(seed)), 1'b1);
		bus_read(REG_STATUS, rdata);
		check_status("frame error set", expected_status(1'b0, 1'b1), rdata[4:0]);
		send_frame(8'($random(seed)), 1'b0);
		read_and_check_rx("frame error next");
		bus_write(REG_STATUS, 32'h1 << ST_FRAME_ERR);
		model_frame_err = 1'b0;
		bus_read(REG_STATUS, rdata);
		check_status("frame error cleared", expected_status(1'b0, 1'b1), rdata[4:0]);

		// Interrupts, bit 1 is transmit and bit 0 receive
		bus_write(REG_IRQ_EN, 32'h3);
		repeat (2) @(negedge uart_clk);
		check_irq("irq tx drained", 2'b10, {irq_tx_o, irq_rx_o});
		send_frame(8'($random(seed)), 1'b0);
		repeat (2) @(negedge uart_clk);
		check_irq("irq rx pending", 2'b11, {irq_tx_o, irq_rx_o});
		write_tx_byte(8'($random(seed)));
		repeat (BIT_CYCLES / 2) @(negedge uart_clk);
		check_irq("irq tx sending", 2'b01, {irq_tx_o, irq_rx_o});
		wait_tx_done("irq tx byte", 1);
		repeat (2) @(negedge uart_clk);
		check_irq("irq tx idle again", 2'b11, {irq_tx_o, irq_rx_o});
		read_and_check_rx("irq rx byte");
		repeat (2) @(negedge uart_clk);
		check_irq("irq rx drained", 2'b10, {irq_tx_o, irq_rx_o});
		bus_write(REG_IRQ_EN, 32'h0);
		send_frame(8'($random(seed)), 1'b0);
		repeat (2) @(negedge uart_clk);
		check_irq("irq disabled", 2'b00, {irq_tx_o, irq_rx_o});
		read_and_check_rx("irq disabled rx byte");

		$display("Checks done: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/uart_top.sv */
// UART top level
// Baud generator, transmit and receive FIFOs, serial engines and registers

`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_top (
	input  wire                        uart_clk,
	input  wire                        reset,
	input  wire                        uart_rx_i,
	output logic                       uart_tx_o,
	output logic                       irq_rx_o,
	output logic                       irq_tx_o,
	input  wire [`UART_BUS_ADR_W-1:0]  bus_adr_i,
	input  wire [`UART_BUS_DAT_W-1:0]  bus_dat_i,
	input  wire                        bus_we_i,
	input  wire                        bus_stb_i,
	output logic [`UART_BUS_DAT_W-1:0] bus_dat_o,
	output logic                       bus_ack_o
);

	import uart_pkg::*;

	logic tick_16x;
	logic tx_idle;
	logic frame_err;
	logic overrun;

	uart_fifo_if tx_fifo_bus ();
	uart_fifo_if rx_fifo_bus ();

	uart_baud_gen u_baud_gen (
		.uart_clk   (uart_clk),
		.reset      (reset),
		.tick_16x_o (tick_16x)
	);

	// --------------------------------------------------
	// FIFOs
	// --------------------------------------------------
	uart_fifo u_tx_fifo (
		.uart_clk  (uart_clk),
		.reset     (reset),
		.fifo_port (tx_fifo_bus)
	);

	uart_fifo u_rx_fifo (
		.uart_clk  (uart_clk),
		.reset     (reset),
		.fifo_port (rx_fifo_bus)
	);

	// --------------------------------------------------
	// Serial engines
	// --------------------------------------------------
	uart_tx u_tx (
		.uart_clk   (uart_clk),
		.reset      (reset),
		.tick_16x_i (tick_16x),
		.fifo_rd    (tx_fifo_bus),
		.uart_tx_o  (uart_tx_o),
		.tx_idle_o  (tx_idle)
	);

	uart_rx u_rx (
		.uart_clk    (uart_clk),
		.reset       (reset),
		.tick_16x_i  (tick_16x),
		.uart_rx_i   (uart_rx_i),
		.fifo_wr     (rx_fifo_bus),
		.frame_err_o (frame_err),
		.overrun_o   (overrun)
	);

	uart_regs u_regs (
		.uart_clk    (uart_clk),
		.reset       (reset),
		.bus_adr_i   (uart_reg_e'(bus_adr_i)),
		.bus_dat_i   (bus_dat_i),
		.bus_we_i    (bus_we_i),
		.bus_stb_i   (bus_stb_i),
		.bus_dat_o   (bus_dat_o),
		.bus_ack_o   (bus_ack_o),
		.tx_wr       (tx_fifo_bus),
		.rx_rd       (rx_fifo_bus),
		.tx_idle_i   (tx_idle),
		.frame_err_i (frame_err),
		.overrun_i   (overrun),
		.irq_rx_o    (irq_rx_o),
		.irq_tx_o    (irq_tx_o)
	);

endmodule

`default_nettype wire

/* verilog/uart_regs.sv */
// UART register block
// Bus decode for data, status and IRQ enable, sticky errors and interrupts

`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_regs (
	input  wire                        uart_clk,
	input  wire                        reset,
	input  uart_pkg::uart_reg_e        bus_adr_i,
	input  wire [`UART_BUS_DAT_W-1:0]  bus_dat_i,
	input  wire                        bus_we_i,
	input  wire                        bus_stb_i,
	output logic [`UART_BUS_DAT_W-1:0] bus_dat_o,
	output logic                       bus_ack_o,
	uart_fifo_if.writer                tx_wr,
	uart_fifo_if.reader                rx_rd,
	input  wire                        tx_idle_i,
	input  wire                        frame_err_i,
	input  wire                        overrun_i,
	output logic                       irq_rx_o,
	output logic                       irq_tx_o
);

	import uart_pkg::*;

	logic                       accept;
	logic                       clr_status;
	logic                       overrun_q;
	logic                       frame_err_q;
	logic [1:0]                 irq_en;
	logic [4:0]                 status;
	logic [`UART_BUS_DAT_W-1:0] rd_data;

	// One access per strobe, the ack cycle itself is not accepted again
	assign accept     = bus_stb_i && !bus_ack_o;
	assign clr_status = accept && bus_we_i && (bus_adr_i == REG_STATUS);

	assign tx_wr.push      = accept && bus_we_i && (bus_adr_i == REG_DATA);
	assign tx_wr.push_data = bus_dat_i[7:0];
	assign rx_rd.pop       = accept && !bus_we_i && (bus_adr_i == REG_DATA) && !rx_rd.empty;

	always_comb begin
		status               = '0;
		status[ST_RX_AVAIL]  = !rx_rd.empty;
		status[ST_TX_FULL]   = tx_wr.full;
		status[ST_TX_IDLE]   = tx_idle_i;
		status[ST_OVERRUN]   = overrun_q;
		status[ST_FRAME_ERR] = frame_err_q;
		case (bus_adr_i)
			REG_DATA:   rd_data = rx_rd.empty ? '0 : {{(`UART_BUS_DAT_W-8){1'b0}}, rx_rd.pop_data};
			REG_STATUS: rd_data = {{(`UART_BUS_DAT_W-5){1'b0}}, status};
			REG_IRQ_EN: rd_data = {{(`UART_BUS_DAT_W-2){1'b0}}, irq_en};
			default:    rd_data = '0;
		endcase
	end

	always_ff @(posedge uart_clk) begin
		if (accept)
			bus_dat_o <= rd_data;
	end

	// --------------------------------------------------
	// Control, sticky flags and interrupts
	// --------------------------------------------------
	always_ff @(posedge uart_clk or posedge reset) begin
		if (reset) begin
			bus_ack_o   <= 1'b0;
			overrun_q   <= 1'b0;
			frame_err_q <= 1'b0;
			irq_en      <= 2'b00;
			irq_rx_o    <= 1'b0;
			irq_tx_o    <= 1'b0;
		end else begin
			bus_ack_o <= accept;
			// New error wins over a clear in the same cycle
			if (overrun_i)
				overrun_q <= 1'b1;
			else if (clr_status && bus_dat_i[ST_OVERRUN])
				overrun_q <= 1'b0;
			if (frame_err_i)
				frame_err_q <= 1'b1;
			else if (clr_status && bus_dat_i[ST_FRAME_ERR])
				frame_err_q <= 1'b0;
			if (accept && bus_we_i && (bus_adr_i == REG_IRQ_EN))
				irq_en <= bus_dat_i[1:0];
			irq_rx_o <= irq_en[0] && !rx_rd.empty;
			irq_tx_o <= irq_en[1] && tx_wr.empty && tx_idle_i;
		end
	end

	a_ack_single: assert property (@(posedge uart_clk) disable iff (reset)
		bus_ack_o |=> !bus_ack_o)
		else $error("Bus ack held for two cycles");

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
// UART receive engine
// Start detection, mid-bit sampling and stop check into the receive FIFO

`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  wire         uart_clk,
	input  wire         reset,
	input  wire         tick_16x_i,
	input  wire         uart_rx_i,
	uart_fifo_if.writer fifo_wr,
	output logic        frame_err_o,
	output logic        overrun_o
);

	import uart_pkg::*;

	uart_rx_state_e state;
	logic           rx_meta;
	logic           rx_sync;
	logic           rx_prev;
	logic [3:0]     tick_cnt;
	logic [2:0]     bit_cnt;
	logic [7:0]     shreg;
	logic           push_q;
	logic           fall_edge;
	logic           sample;

	assign fall_edge = rx_prev && !rx_sync;
	// 16 ticks after the start bit middle lands in the next bit middle
	assign sample    = tick_16x_i && (tick_cnt == 4'd15);

	assign fifo_wr.push      = push_q;
	assign fifo_wr.push_data = shreg;

	// --------------------------------------------------
	// Line synchronizer
	// --------------------------------------------------
	always_ff @(posedge uart_clk or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge uart_clk) begin
		if (state == RX_DATA && sample)
			shreg <= {rx_sync, shreg[7:1]};
	end

	// --------------------------------------------------
	// Frame FSM
	// --------------------------------------------------
	always_ff @(posedge uart_clk or posedge reset) begin
		if (reset) begin
			state       <= RX_IDLE;
			tick_cnt    <= '0;
			bit_cnt     <= '0;
			push_q      <= 1'b0;
			frame_err_o <= 1'b0;
			overrun_o   <= 1'b0;
		end else begin
			push_q      <= 1'b0;
			frame_err_o <= 1'b0;
			overrun_o   <= 1'b0;
			if (state != RX_IDLE && tick_16x_i)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					if (fall_edge) begin
						state    <= RX_START;
						tick_cnt <= '0;
					end
				end
				RX_START: begin
					// Recheck at tick 8, a glitch goes back to idle
					if (tick_16x_i && tick_cnt == 4'd7) begin
						if (!rx_sync) begin
							state    <= RX_DATA;
							tick_cnt <= '0;
							bit_cnt  <= '0;
						end else begin
							state <= RX_IDLE;
						end
					end
				end
				RX_DATA: begin
					if (sample) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (sample) begin
						state <= RX_IDLE;
						if (!rx_sync)
							frame_err_o <= 1'b1;
						else if (fifo_wr.full)
							overrun_o <= 1'b1;
						else
							push_q <= 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	a_no_push_full: assert property (@(posedge uart_clk) disable iff (reset)
		fifo_wr.push |-> !fifo_wr.full)
		else $error("RX push into full FIFO");

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
// UART transmit engine
// Pops bytes from the transmit FIFO and shifts out 8N1 frames

`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  wire         uart_clk,
	input  wire         reset,
	input  wire         tick_16x_i,
	uart_fifo_if.reader fifo_rd,
	output logic        uart_tx_o,
	output logic        tx_idle_o
);

	import uart_pkg::*;

	uart_tx_state_e state;
	logic [3:0]     tick_cnt;
	logic [2:0]     bit_cnt;
	logic [7:0]     shreg;
	logic           start_frame;
	logic           bit_end;

	// Frames start on a tick so the start bit is a full 16 ticks
	assign start_frame = (state == TX_IDLE) && tick_16x_i && !fifo_rd.empty;
	assign bit_end     = tick_16x_i && (tick_cnt == 4'd15);
	assign fifo_rd.pop = start_frame;
	assign tx_idle_o   = (state == TX_IDLE);

	always_ff @(posedge uart_clk) begin
		if (start_frame)
			shreg <= fifo_rd.pop_data;
	end

	always_ff @(posedge uart_clk or posedge reset) begin
		if (reset) begin
			state     <= TX_IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			uart_tx_o <= 1'b1;
		end else begin
			if (state != TX_IDLE && tick_16x_i)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					if (start_frame) begin
						state     <= TX_START;
						tick_cnt  <= '0;
						uart_tx_o <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state     <= TX_DATA;
						bit_cnt   <= '0;
						uart_tx_o <= shreg[0];
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_cnt == 3'd7) begin
							state     <= TX_STOP;
							uart_tx_o <= 1'b1;
						end else begin
							// LSB first
							bit_cnt   <= bit_cnt + 1'b1;
							uart_tx_o <= shreg[bit_cnt + 3'd1];
						end
					end
				end
				TX_STOP: begin
					if (bit_end)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	a_idle_high: assert property (@(posedge uart_clk) disable iff (reset)
		(state == TX_IDLE) |-> uart_tx_o)
		else $error("TX line low while idle");

endmodule

`default_nettype wire

/* verilog/uart_fifo.sv */
// UART byte FIFO
// Synchronous circular buffer with full, empty and occupancy count

`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_fifo (
	input  wire       uart_clk,
	input  wire       reset,
	uart_fifo_if.fifo fifo_port
);

	localparam int AW    = `UART_FIFO_DEPTH_LOG2;
	localparam int DEPTH = 1 << AW;

	logic [7:0]  mem [0:DEPTH-1];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	// Push while full and pop while empty are dropped here
	assign do_push = fifo_port.push && !fifo_port.full;
	assign do_pop  = fifo_port.pop && !fifo_port.empty;

	assign fifo_port.full     = (count == (AW+1)'(DEPTH));
	assign fifo_port.empty    = (count == '0);
	assign fifo_port.count    = count;
	// Head entry is always visible
	assign fifo_port.pop_data = mem[rd_ptr];

	always_ff @(posedge uart_clk) begin
		if (do_push)
			mem[wr_ptr] <= fifo_port.push_data;
	end

	// --------------------------------------------------
	// Pointers and occupancy
	// --------------------------------------------------
	always_ff @(posedge uart_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_count_bound: assert property (@(posedge uart_clk) disable iff (reset)
		fifo_port.count <= (AW+1)'(DEPTH))
		else $error("FIFO occupancy above depth");

	a_full_empty: assert property (@(posedge uart_clk) disable iff (reset)
		!(fifo_port.full && fifo_port.empty))
		else $error("FIFO full and empty at once");

endmodule

`default_nettype wire

/* verilog/uart_baud_gen.sv */
// UART baud generator
// Divides uart_clk down to a one-cycle 16x oversampling enable

`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_baud_gen (
	input  wire  uart_clk,
	input  wire  reset,
	output logic tick_16x_o
);

	localparam int unsigned DIV   = `UART_BAUD_DIV;
	localparam int unsigned CNT_W = $clog2(DIV + 1);

	logic [CNT_W-1:0] div_cnt;

	// Down-counter, tick on wrap then reload
	always_ff @(posedge uart_clk or posedge reset) begin
		if (reset) begin
			div_cnt    <= CNT_W'(DIV - 1);
			tick_16x_o <= 1'b0;
		end else begin
			if (div_cnt == '0) begin
				div_cnt    <= CNT_W'(DIV - 1);
				tick_16x_o <= 1'b1;
			end else begin
				div_cnt    <= div_cnt - 1'b1;
				tick_16x_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/uart_fifo_if.sv */
// UART FIFO interface
// Push side, pop side and flags of one byte FIFO

`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

interface uart_fifo_if;

	logic                             push;
	logic [7:0]                       push_data;
	logic                             full;
	logic                             pop;
	logic [7:0]                       pop_data;
	logic                             empty;
	logic [`UART_FIFO_DEPTH_LOG2:0]   count;

	modport writer (output push, output push_data, input full, input empty);
	modport reader (output pop, input pop_data, input empty);
	modport fifo (
		input  push, input push_data, input pop,
		output full, output pop_data, output empty, output count
	);

endinterface

`default_nettype wire

/* verilog/uart_pkg.sv */
// UART shared types
// Register map, engine state encodings and status bit positions

`default_nettype none

package uart_pkg;

	// Register addresses on the bus
	typedef enum logic [1:0] {
		REG_DATA   = 2'd0,
		REG_STATUS = 2'd1,
		REG_IRQ_EN = 2'd2
	} uart_reg_e;

	// Transmit engine states
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} uart_tx_state_e;

	// Receive engine states
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} uart_rx_state_e;

	// Status register layout
	localparam int ST_RX_AVAIL  = 0;
	localparam int ST_TX_FULL   = 1;
	localparam int ST_TX_IDLE   = 2;
	localparam int ST_OVERRUN   = 3;
	localparam int ST_FRAME_ERR = 4;

endpackage

`default_nettype wire

/* uart_settings.svh */
// UART build-time settings
// Baud divisor, FIFO depth and register bus widths

`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// uart_clk cycles per 16x oversampling tick
`define UART_BAUD_DIV 27

// FIFO address width, 16 entries
`define UART_FIFO_DEPTH_LOG2 4

// Register bus
`define UART_BUS_ADR_W 2
`define UART_BUS_DAT_W 32

`endif
